// ==== design/ice_basics_defines.svh ====
`ifndef ICE_BASICS_DEFINES_SVH
`define ICE_BASICS_DEFINES_SVH

// Command bytes
`define ICE_CMD_VER       8'h76
`define ICE_CMD_Q_I2C     8'h49
`define ICE_CMD_S_I2C     8'h69
`define ICE_CMD_Q_GOC     8'h4F
`define ICE_CMD_S_GOC     8'h6F

// Subcommands, GOC falls back to speed on anything else
`define ICE_SUB_SPEED     8'h63
`define ICE_SUB_ADDR      8'h61
`define ICE_SUB_POL       8'h6F
`define ICE_SUB_MODE      8'h70

`define ICE_RESP_ACK      8'h41
`define ICE_RESP_NAK      8'h4E

`define ICE_VER_MAJOR     8'h00
`define ICE_VER_MINOR     8'h02

// Setting values out of reset
`define ICE_RST_I2C_SPEED 8'd99
`define ICE_RST_I2C_ADDR  16'hFFFF
`define ICE_RST_GOC_SPEED 22'h30D400
`define ICE_RST_GOC_MODE  1'b1

// Response path sizing
`define ICE_RESP_CREDITS  4
`define ICE_RESP_DEPTH    8

`endif

// ==== design/ice_basics_pkg.sv ====
`default_nettype none

package ice_basics_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [21:0] goc_speed_t;
	typedef logic [15:0] i2c_addr_t;

	// Master bus as seen by the handler
	typedef struct packed {
		byte_t data;
		logic  valid;
		logic  frame;
	} ma_bus_t;

	// One received byte with its position in the frame
	typedef struct packed {
		byte_t data;
		logic  start;
		logic  eid;
		logic  payload;
	} rx_byte_t;

	typedef struct packed {
		byte_t data;
		logic  last;
	} resp_byte_t;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_I2C_SPEED,
		SEL_I2C_ADDR,
		SEL_GOC_SPEED,
		SEL_GOC_POL,
		SEL_GOC_MODE
	} param_sel_t;

	typedef enum logic [2:0] {
		IDLE,
		HDR,
		SUB,
		VER,
		SET_DATA,
		SEND_HDR,
		SEND_DATA
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/ice_frame_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module ice_frame_rx import ice_basics_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire ma_bus_t ma,
	output rx_byte_t     rx
);

	logic       frame_q;
	logic [1:0] cnt;
	logic       start;

	// Rising edge of the frame bit marks the command byte
	assign start = ma.valid && ma.frame && !frame_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			frame_q <= 1'b0;
			cnt <= '0;
			rx <= '0;
		end else begin
			frame_q <= ma.frame;
			rx.data <= ma.data;
			rx.start <= start;
			rx.eid <= ma.valid && ma.frame && !start && (cnt == 2'd1);
			// Third byte is the length and gets no flag
			rx.payload <= ma.valid && ma.frame && !start && (cnt == 2'd3);
			if (start)
				cnt <= 2'd1;
			else if (!ma.frame)
				cnt <= '0;
			else if (ma.valid && cnt != 2'd3)
				cnt <= cnt + 2'd1;
		end
	end

endmodule

`default_nettype wire

// ==== design/ice_basics_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ice_basics_defines.svh"

module ice_basics_ctrl import ice_basics_pkg::*; (
	input  wire           clk,
	input  wire           rst,
	input  wire rx_byte_t rx,
	input  wire           nak_request,
	input  wire byte_t    param_byte,
	input  wire           room,
	output param_sel_t    param_sel,
	output logic          param_load,
	output logic          param_shift,
	output logic          param_wr,
	output logic          push,
	output resp_byte_t    push_byte
);

	ctrl_state_t state;
	logic [1:0]  cnt;
	logic        phase;
	logic        nak_q;
	logic        nak_cmd;
	byte_t       cmd;
	byte_t       eid;
	byte_t       code;
	byte_t       ver_hi;
	param_sel_t  sel;
	param_sel_t  sub_sel;
	logic        known_cmd;
	logic        i2c_cmd;
	logic        is_query;
	logic        ver_match;

	function automatic logic [1:0] sel_bytes(param_sel_t s);
		case (s)
			SEL_I2C_ADDR:  return 2'd2;
			SEL_GOC_SPEED: return 2'd3;
			default:       return 2'd1;
		endcase
	endfunction

	assign known_cmd = rx.data inside {`ICE_CMD_VER, `ICE_CMD_Q_I2C, `ICE_CMD_S_I2C,
		`ICE_CMD_Q_GOC, `ICE_CMD_S_GOC};
	assign i2c_cmd = (cmd == `ICE_CMD_Q_I2C) || (cmd == `ICE_CMD_S_I2C);
	assign is_query = (cmd == `ICE_CMD_Q_I2C) || (cmd == `ICE_CMD_Q_GOC);
	assign ver_match = {ver_hi, rx.data} == {`ICE_VER_MAJOR, `ICE_VER_MINOR};
	assign param_wr = (state == SET_DATA) && rx.payload;
	assign param_sel = sel;

	// Subcommand decode, only used on the first payload byte
	always_comb begin
		sub_sel = SEL_NONE;
		if (i2c_cmd) begin
			if (rx.data == `ICE_SUB_SPEED)
				sub_sel = SEL_I2C_SPEED;
			else if (rx.data == `ICE_SUB_ADDR)
				sub_sel = SEL_I2C_ADDR;
		end else if (rx.data == `ICE_SUB_POL) begin
			sub_sel = SEL_GOC_POL;
		end else if (rx.data == `ICE_SUB_MODE) begin
			sub_sel = SEL_GOC_MODE;
		end else begin
			sub_sel = SEL_GOC_SPEED;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && rx.start) begin
			cmd <= rx.data;
			nak_cmd <= nak_q;
		end
		if (state == HDR && rx.eid)
			eid <= rx.data;
		if (state == VER && rx.payload && cnt == 2'd2)
			ver_hi <= rx.data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cnt <= '0;
			phase <= 1'b0;
			nak_q <= 1'b0;
			sel <= SEL_NONE;
		end else begin
			// nak_request arrives with the bus byte, one cycle ahead of rx
			nak_q <= nak_request;
			case (state)
				IDLE: begin
					if (rx.start && room && (nak_q || known_cmd))
						state <= HDR;
				end
				HDR: begin
					if (rx.eid) begin
						if (nak_cmd) begin
							code <= `ICE_RESP_NAK;
							cnt <= 2'd0;
							state <= SEND_HDR;
						end else if (cmd == `ICE_CMD_VER) begin
							cnt <= 2'd2;
							state <= VER;
						end else begin
							state <= SUB;
						end
					end
				end
				VER: begin
					if (rx.payload) begin
						if (cnt == 2'd2) begin
							cnt <= 2'd1;
						end else begin
							code <= ver_match ? `ICE_RESP_ACK : `ICE_RESP_NAK;
							// Mismatch answers with our own version
							cnt <= ver_match ? 2'd0 : 2'd2;
							state <= SEND_HDR;
						end
					end
				end
				SUB: begin
					if (rx.payload) begin
						sel <= sub_sel;
						if (sub_sel == SEL_NONE) begin
							code <= `ICE_RESP_NAK;
							cnt <= 2'd0;
							state <= SEND_HDR;
						end else begin
							code <= `ICE_RESP_ACK;
							cnt <= sel_bytes(sub_sel);
							state <= is_query ? SEND_HDR : SET_DATA;
						end
					end
				end
				SET_DATA: begin
					if (rx.payload) begin
						cnt <= cnt - 2'd1;
						if (cnt == 2'd1)
							state <= SEND_HDR;
					end
				end
				SEND_HDR: begin
					phase <= !phase;
					if (phase)
						state <= (cnt == 2'd0) ? IDLE : SEND_DATA;
				end
				SEND_DATA: begin
					cnt <= cnt - 2'd1;
					if (cnt == 2'd1)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Code then EID, then payload bytes
	always_comb begin
		push = 1'b0;
		push_byte = '0;
		param_load = 1'b0;
		param_shift = 1'b0;
		case (state)
			SEND_HDR: begin
				push = 1'b1;
				push_byte.data = phase ? eid : code;
				push_byte.last = phase && (cnt == 2'd0);
				param_load = !phase && is_query;
			end
			SEND_DATA: begin
				push = 1'b1;
				param_shift = is_query;
				push_byte.last = (cnt == 2'd1);
				if (cmd == `ICE_CMD_VER)
					push_byte.data = (cnt == 2'd2) ? `ICE_VER_MAJOR : `ICE_VER_MINOR;
				else
					push_byte.data = param_byte;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/ice_param_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ice_basics_defines.svh"

module ice_param_regs import ice_basics_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire param_sel_t param_sel,
	input  wire             param_load,
	input  wire             param_shift,
	input  wire             param_wr,
	input  wire byte_t      wr_byte,
	output byte_t           param_byte,
	output byte_t           i2c_speed,
	output i2c_addr_t       i2c_addr,
	output goc_speed_t      goc_speed,
	output logic            goc_polarity,
	output logic            goc_mode
);

	logic [23:0] shreg;

	assign param_byte = shreg[23:16];

	// Multi-byte settings arrive MSB first
	always_ff @(posedge clk) begin
		if (rst) begin
			i2c_speed <= `ICE_RST_I2C_SPEED;
			i2c_addr <= `ICE_RST_I2C_ADDR;
			goc_speed <= `ICE_RST_GOC_SPEED;
			goc_polarity <= 1'b0;
			goc_mode <= `ICE_RST_GOC_MODE;
		end else if (param_wr) begin
			case (param_sel)
				SEL_I2C_SPEED: i2c_speed <= wr_byte;
				SEL_I2C_ADDR:  i2c_addr <= {i2c_addr[7:0], wr_byte};
				SEL_GOC_SPEED: goc_speed <= {goc_speed[13:0], wr_byte};
				SEL_GOC_POL:   goc_polarity <= wr_byte[0];
				SEL_GOC_MODE:  goc_mode <= wr_byte[0];
				default: ;
			endcase
		end
	end

	// Query shifter, left aligned so the top byte goes first
	always_ff @(posedge clk) begin
		if (param_load) begin
			case (param_sel)
				SEL_I2C_SPEED: shreg <= {i2c_speed, 16'h0000};
				SEL_I2C_ADDR:  shreg <= {i2c_addr, 8'h00};
				SEL_GOC_SPEED: shreg <= {2'b00, goc_speed};
				SEL_GOC_POL:   shreg <= {7'd0, goc_polarity, 16'h0000};
				SEL_GOC_MODE:  shreg <= {7'd0, goc_mode, 16'h0000};
				default:       shreg <= '0;
			endcase
		end else if (param_shift) begin
			shreg <= {shreg[15:0], 8'h00};
		end
	end

endmodule

`default_nettype wire

// ==== design/ice_resp_tx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ice_basics_defines.svh"

module ice_resp_tx import ice_basics_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire             push,
	input  wire resp_byte_t push_byte,
	input  wire             resp_credit,
	output logic            room,
	output resp_byte_t      resp,
	output logic            resp_valid
);

	localparam int PTR_W = $clog2(`ICE_RESP_DEPTH);
	localparam int CNT_W = $clog2(`ICE_RESP_DEPTH + 1);
	localparam int CRD_W = $clog2(`ICE_RESP_CREDITS + 1);
	// Code, EID and up to three payload bytes
	localparam int MAX_RESP = 5;

	resp_byte_t       mem [`ICE_RESP_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic [CRD_W-1:0] credits;
	logic             pop;

	assign resp_valid = (fill != '0) && (credits != '0);
	assign pop = resp_valid;
	assign resp = mem[rd_ptr];
	assign room = fill <= CNT_W'(`ICE_RESP_DEPTH - MAX_RESP);

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_byte;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			credits <= CRD_W'(`ICE_RESP_CREDITS);
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fill <= fill + CNT_W'(push) - CNT_W'(pop);
			// One credit per byte sent, one back per consumer pulse
			credits <= credits + CRD_W'(resp_credit) - CRD_W'(pop);
		end
	end

endmodule

`default_nettype wire

// ==== design/ice_basics.sv ====
`timescale 1ns/10ps
`default_nettype none

module ice_basics import ice_basics_pkg::*; (
	input  wire          clk,
	input  wire          rst,
	input  wire ma_bus_t ma,
	input  wire          nak_request,
	input  wire          resp_credit,
	output resp_byte_t   resp,
	output logic         resp_valid,
	output byte_t        i2c_speed,
	output i2c_addr_t    i2c_addr,
	output goc_speed_t   goc_speed,
	output logic         goc_polarity,
	output logic         goc_mode
);

	rx_byte_t   rx;
	param_sel_t param_sel;
	logic       param_load;
	logic       param_shift;
	logic       param_wr;
	byte_t      param_byte;
	logic       room;
	logic       push;
	resp_byte_t push_byte;

	ice_frame_rx i_rx (
		.clk(clk), .rst(rst), .ma(ma), .rx(rx)
	);

	ice_basics_ctrl i_ctrl (
		.clk(clk), .rst(rst), .rx(rx), .nak_request(nak_request),
		.param_byte(param_byte), .room(room), .param_sel(param_sel),
		.param_load(param_load), .param_shift(param_shift), .param_wr(param_wr),
		.push(push), .push_byte(push_byte)
	);

	// Set writes take the payload byte straight from the receiver
	ice_param_regs i_regs (
		.clk(clk), .rst(rst), .param_sel(param_sel), .param_load(param_load),
		.param_shift(param_shift), .param_wr(param_wr), .wr_byte(rx.data),
		.param_byte(param_byte), .i2c_speed(i2c_speed), .i2c_addr(i2c_addr),
		.goc_speed(goc_speed), .goc_polarity(goc_polarity), .goc_mode(goc_mode)
	);

	ice_resp_tx i_tx (
		.clk(clk), .rst(rst), .push(push), .push_byte(push_byte),
		.resp_credit(resp_credit), .room(room), .resp(resp), .resp_valid(resp_valid)
	);

endmodule

`default_nettype wire

// ==== tests/ice_basics_chk.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ice_basics_defines.svh"

module ice_basics_chk #(
	parameter int CNT_W = 4
) (
	input wire             clk,
	input wire             rst,
	input wire             push,
	input wire             resp_valid,
	input wire             resp_credit,
	input wire [CNT_W-1:0] fill
);

	int fails = 0;
	int held;

	// Credits as seen from the consumer side of the handshake
	always_ff @(posedge clk) begin
		if (rst)
			held <= `ICE_RESP_CREDITS;
		else
			held <= held + int'(resp_credit) - int'(resp_valid);
	end

	// A byte may only leave while a credit is held
	a_valid_needs_credit: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> held > 0)
	else begin
		$error("resp_valid high with no credits left");
		fails++;
	end

	a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
		push |-> fill != CNT_W'(`ICE_RESP_DEPTH))
	else begin
		$error("push into a full response queue");
		fails++;
	end

	// First reset edge clears the fill count
	a_quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !resp_valid)
	else begin
		$error("resp_valid high during reset");
		fails++;
	end

endmodule

bind ice_resp_tx ice_basics_chk #(.CNT_W(CNT_W)) i_chk (.*);

`default_nettype wire

// ==== tests/ice_basics_mon.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ice_basics_defines.svh"

module ice_basics_mon import ice_basics_pkg::*; (
	input wire             clk,
	input wire             rst,
	input wire resp_byte_t resp,
	input wire             resp_valid,
	input wire             resp_credit,
	input wire byte_t      i2c_speed,
	input wire i2c_addr_t  i2c_addr,
	input wire goc_speed_t goc_speed,
	input wire             goc_polarity,
	input wire             goc_mode
);

	byte_t exp_data [$];
	logic  exp_last [$];
	int    mismatches = 0;
	int    other_errors = 0;
	int    sent = 0;
	int    granted = 0;

	task automatic compare_value(input string name, input logic [23:0] got,
		input logic [23:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, want);
			mismatches++;
		end
	endtask

	task automatic expect_resp(input byte_t data, input logic last);
		exp_data.push_back(data);
		exp_last.push_back(last);
	endtask

	function automatic int pending();
		return exp_data.size();
	endfunction

	task automatic check_settings(input byte_t speed, input i2c_addr_t addr,
		input goc_speed_t gspeed, input logic pol, input logic mode);
		compare_value("i2c_speed", i2c_speed, speed);
		compare_value("i2c_addr", i2c_addr, addr);
		compare_value("goc_speed", goc_speed, gspeed);
		compare_value("goc_polarity", goc_polarity, pol);
		compare_value("goc_mode", goc_mode, mode);
	endtask

	always @(negedge clk) begin
		if (!rst && resp_valid) begin
			// Credits granted before this edge plus the initial stock
			if (sent >= granted + `ICE_RESP_CREDITS) begin
				$display("Response byte at %0t left without a credit", $time);
				other_errors++;
			end
			sent++;
			if (exp_data.size() == 0) begin
				$display("Response byte %0h at %0t was not expected", resp.data, $time);
				other_errors++;
			end else begin
				compare_value("resp.data", resp.data, exp_data.pop_front());
				compare_value("resp.last", resp.last, exp_last.pop_front());
			end
		end
		if (!rst && resp_credit)
			granted++;
	end

	task automatic report(input int assert_fails, output int total);
		if (exp_data.size() != 0) begin
			$display("%0d expected response bytes never arrived", exp_data.size());
			other_errors++;
		end
		total = mismatches + other_errors + assert_fails;
		$display("Error counts: %0d mismatches, %0d other errors, %0d assertion failures",
			mismatches, other_errors, assert_fails);
	endtask

endmodule

`default_nettype wire

// ==== tests/tb_ice_basics.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ice_basics import ice_basics_pkg::*; ();

	localparam STIM_FILE = "tests/ice_basics_stimulus.txt";

	logic       clk;
	logic       rst;
	ma_bus_t    ma;
	logic       nak_request;
	logic       resp_credit;
	resp_byte_t resp;
	logic       resp_valid;
	byte_t      i2c_speed;
	i2c_addr_t  i2c_addr;
	goc_speed_t goc_speed;
	logic       goc_polarity;
	logic       goc_mode;

	integer seed;
	int     cycle;
	int     limit;
	int     credit_max;
	int     credit_due [$];
	int     gaps [$];

	ice_basics i_dut (.*);

	ice_basics_mon i_mon (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		int total;
		cycle <= cycle + 1;
		if (limit > 0 && cycle >= limit) begin
			$display("Timeout: run still busy after %0d cycles", limit);
			i_mon.report(i_dut.i_tx.i_chk.fails, total);
			$display("Test failed");
			$finish;
		end
	end

	// Consumer hands each credit back after a random delay
	always @(posedge clk) begin
		int due;
		if (rst) begin
			resp_credit <= 1'b0;
		end else begin
			if (resp_valid) begin
				due = cycle + 1 + ({$random(seed)} % credit_max);
				credit_due.push_back(due);
			end
			if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
				resp_credit <= 1'b1;
				void'(credit_due.pop_front());
			end else begin
				resp_credit <= 1'b0;
			end
		end
	end

	function automatic int count_frames();
		int               fd;
		int               rc;
		int               n;
		byte_t            tag;
		logic [8*128-1:0] line;
		n = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0) begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				if (tag == "F")
					n++;
				rc = $fgets(line, fd);
			end
			$fclose(fd);
		end
		return n;
	endfunction

	task automatic run_frame(input int fd);
		int          rc;
		int unsigned nak;
		int unsigned n;
		int unsigned m;
		int unsigned v;
		byte_t       req [$];
		rc = $fscanf(fd, "%h %h", nak, n);
		for (int i = 0; i < n; i++) begin
			rc = $fscanf(fd, "%h", v);
			req.push_back(byte_t'(v));
		end
		rc = $fscanf(fd, "%h", m);
		// Queue must have room for a full response when the frame starts
		while (i_mon.pending() > 3)
			@(posedge clk);
		for (int i = 0; i < m; i++) begin
			rc = $fscanf(fd, "%h", v);
			i_mon.expect_resp(byte_t'(v), i == m - 1);
		end
		foreach (req[i]) begin
			ma.data <= req[i];
			ma.valid <= 1'b1;
			ma.frame <= 1'b1;
			nak_request <= (i == 0) && nak[0];
			@(posedge clk);
		end
		ma <= '0;
		nak_request <= 1'b0;
		repeat (gaps.pop_front())
			@(posedge clk);
	endtask

	initial begin
		int               fd;
		int               rc;
		int               total;
		int               nframes;
		byte_t            tag;
		logic [8*128-1:0] line;
		int unsigned      s [5];
		clk = 1'b0;
		rst = 1'b1;
		ma = '0;
		nak_request = 1'b0;
		resp_credit = 1'b0;
		seed = 32'h41d12d99;
		cycle = 0;
		credit_max = 3;
		nframes = count_frames();
		limit = 40 * nframes + 200;
		// Idle gap after each frame, 12 to 20 cycles
		repeat (nframes)
			gaps.push_back(12 + {$random(seed)} % 9);
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file %s", STIM_FILE);
			$display("Test failed");
		end else begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				case (tag)
					"F": run_frame(fd);
					"S": begin
						rc = $fscanf(fd, "%h %h %h %h %h", s[0], s[1], s[2], s[3], s[4]);
						i_mon.check_settings(byte_t'(s[0]), i2c_addr_t'(s[1]),
							goc_speed_t'(s[2]), s[3][0], s[4][0]);
					end
					"C": rc = $fscanf(fd, "%d", credit_max);
					default: rc = $fgets(line, fd);
				endcase
			end
			$fclose(fd);
			// Drain, then watch a while for stray bytes
			while (i_mon.pending() != 0)
				@(posedge clk);
			repeat (40) @(posedge clk);
			i_mon.report(i_dut.i_tx.i_chk.fails, total);
			if (total == 0)
				$display("Test passed");
			else
				$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+design
design/ice_basics_pkg.sv
design/ice_frame_rx.sv
design/ice_basics_ctrl.sv
design/ice_param_regs.sv
design/ice_resp_tx.sv
design/ice_basics.sv
tests/ice_basics_chk.sv
tests/ice_basics_mon.sv
tests/tb_ice_basics.sv

// ==== Bender.yml ====
package:
  name: ice_basics

sources:
  - include_dirs:
      - design
    files:
      - design/ice_basics_pkg.sv
      - design/ice_frame_rx.sv
      - design/ice_basics_ctrl.sv
      - design/ice_param_regs.sv
      - design/ice_resp_tx.sv
      - design/ice_basics.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/ice_basics_chk.sv
      - tests/ice_basics_mon.sv
      - tests/tb_ice_basics.sv

// ==== tests/ice_basics_stimulus.txt ====
# F nak n request-bytes m expected-response-bytes (hex, last flag on the final byte)
# S i2c_speed i2c_addr goc_speed goc_polarity goc_mode (hex), C max credit delay (decimal)
S 63 ffff 30d400 0 1
F 0 4 49 01 01 63 3 41 01 63
F 0 4 49 02 01 61 4 41 02 ff ff
F 0 4 4f 03 01 63 5 41 03 30 d4 00
F 0 4 4f 04 01 6f 3 41 04 00
F 0 4 4f 05 01 70 3 41 05 01
F 0 4 4f 06 01 12 5 41 06 30 d4 00
F 0 5 76 07 02 00 02 2 41 07
F 0 5 76 08 02 01 05 4 4e 08 00 02
F 0 5 69 09 02 63 0a 2 41 09
F 0 6 69 0a 03 61 12 34 2 41 0a
F 0 7 6f 0b 04 63 ff ab cd 2 41 0b
F 0 5 6f 0c 02 6f 01 2 41 0c
F 0 5 6f 0d 02 70 00 2 41 0d
S 0a 1234 3fabcd 1 0
F 0 4 49 0e 01 63 3 41 0e 0a
F 0 4 49 0f 01 61 4 41 0f 12 34
F 0 4 4f 10 01 63 5 41 10 3f ab cd
F 0 4 4f 11 01 6f 3 41 11 01
F 0 4 4f 12 01 70 3 41 12 00
F 1 4 49 13 01 63 2 4e 13
F 1 3 00 14 00 2 4e 14
F 0 4 55 15 01 63 0
F 0 5 69 16 02 7a 44 2 4e 16
F 0 4 49 17 01 7a 2 4e 17
S 0a 1234 3fabcd 1 0
C 24
F 0 5 76 20 02 00 02 2 41 20
F 0 4 4f 21 01 6f 3 41 21 01
F 0 4 49 22 01 61 4 41 22 12 34
F 0 4 4f 23 01 63 5 41 23 3f ab cd
F 0 5 76 24 02 00 03 4 4e 24 00 02
F 1 3 49 25 00 2 4e 25
